// File: common/rv32i_pkg.sv
package rv32i_pkg;

  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  ////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // The low three bits follow funct3, the top bit is the alternate form
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_PC4  = 2'd1,
    WB_LOAD = 2'd2,
    WB_IMM  = 2'd3
  } wb_sel_t;

  // Data window on the APB port, the end bound is exclusive
  localparam logic [XLEN-1:0] DATA_BASE = 32'h0000_2000;
  localparam logic [XLEN-1:0] DATA_END  = 32'h0000_2400;

  ////////////////////////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } instr_t;

endpackage

// File: core/rv32i_registers.sv
module rv32i_registers (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [rv32i_pkg::REG_BITS-1:0] rs1_addr_i,
  input  logic [rv32i_pkg::REG_BITS-1:0] rs2_addr_i,
  input  logic [rv32i_pkg::REG_BITS-1:0] rd_addr_i,
  input  logic                          rd_write_i,
  input  logic [rv32i_pkg::XLEN-1:0]     rd_data_i,
  input  logic                          pc_write_i,
  input  logic [rv32i_pkg::XLEN-1:0]     pc_data_i,
  output logic [rv32i_pkg::XLEN-1:0]     rs1_o,
  output logic [rv32i_pkg::XLEN-1:0]     rs2_o,
  output logic [rv32i_pkg::XLEN-1:0]     pc_o
);

  // x0 has no storage, so the array starts at index 1
  logic [rv32i_pkg::XLEN-1:0] regs [1:2**rv32i_pkg::REG_BITS-1];
  logic [rv32i_pkg::XLEN-1:0] pc_q;

  always_ff @(posedge clk_i) begin
    if (rd_write_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else if (pc_write_i) begin
      pc_q <= pc_data_i;
    end
  end

  // Reads are combinational and x0 always returns zero
  assign rs1_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
  assign pc_o  = pc_q;

endmodule

// File: core/rv32i_decode.sv
module rv32i_decode (
  input  logic [rv32i_pkg::XLEN-1:0]     instr_i,
  output logic [rv32i_pkg::REG_BITS-1:0] rs1_addr_o,
  output logic [rv32i_pkg::REG_BITS-1:0] rs2_addr_o,
  output logic [rv32i_pkg::REG_BITS-1:0] rd_addr_o,
  output logic [rv32i_pkg::XLEN-1:0]     imm_o,
  output rv32i_pkg::alu_op_t             alu_op_o,
  output logic                          op2_imm_o,
  output logic                          op1_pc_o,
  output rv32i_pkg::wb_sel_t             wb_sel_o,
  output logic                          rd_write_o,
  output logic                          branch_o,
  output logic                          jump_o,
  output logic                          jalr_o,
  output logic [2:0]                    funct3_o,
  output logic                          mem_read_o,
  output logic                          mem_write_o,
  output logic                          ebreak_o,
  output logic                          illegal_o
);

  rv32i_pkg::instr_t instr;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              alt_op;
  logic              is_ebreak;

  assign instr  = rv32i_pkg::instr_t'(instr_i);
  assign opcode = instr.r_fmt.opcode;
  assign funct3 = instr.r_fmt.funct3;
  assign funct7 = instr.r_fmt.funct7;

  assign rs1_addr_o = instr.r_fmt.rs1;
  assign rs2_addr_o = instr.r_fmt.rs2;
  assign rd_addr_o  = instr.r_fmt.rd;
  assign funct3_o   = funct3;

  // Bit 30 means SUB only on register OP, but SRA on both shift forms
  assign alt_op = funct7[5] &&
                  (((opcode == rv32i_pkg::OPC_OP) && (funct3 == 3'b000)) ||
                   (funct3 == 3'b101));

  assign is_ebreak = (instr.i_fmt.imm == 12'd1) && (instr.i_fmt.rs1 == '0) &&
                     (funct3 == 3'b000) && (instr.i_fmt.rd == '0);

  ////////////////////////////////////////////////////////////
  // Immediate
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (opcode)
      rv32i_pkg::OPC_OPIMM, rv32i_pkg::OPC_LOAD, rv32i_pkg::OPC_JALR:
        imm_o = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
      rv32i_pkg::OPC_STORE:
        imm_o = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      rv32i_pkg::OPC_BRANCH:
        imm_o = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                 instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
      rv32i_pkg::OPC_LUI, rv32i_pkg::OPC_AUIPC:
        imm_o = {instr.u_fmt.imm, 12'b0};
      rv32i_pkg::OPC_JAL:
        imm_o = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                 instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
      default:
        imm_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op_o    = rv32i_pkg::ALU_ADD;
    op2_imm_o   = 1'b1;
    op1_pc_o    = 1'b0;
    wb_sel_o    = rv32i_pkg::WB_ALU;
    rd_write_o  = 1'b0;
    branch_o    = 1'b0;
    jump_o      = 1'b0;
    jalr_o      = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    ebreak_o    = 1'b0;
    illegal_o   = 1'b0;
    case (opcode)
      rv32i_pkg::OPC_LUI: begin
        rd_write_o = 1'b1;
        wb_sel_o   = rv32i_pkg::WB_IMM;
      end
      rv32i_pkg::OPC_AUIPC: begin
        rd_write_o = 1'b1;
        op1_pc_o   = 1'b1;
      end
      // Jumps and branches use the ALU for pc plus imm
      rv32i_pkg::OPC_JAL: begin
        rd_write_o = 1'b1;
        wb_sel_o   = rv32i_pkg::WB_PC4;
        op1_pc_o   = 1'b1;
        jump_o     = 1'b1;
      end
      rv32i_pkg::OPC_JALR: begin
        rd_write_o = 1'b1;
        wb_sel_o   = rv32i_pkg::WB_PC4;
        jalr_o     = 1'b1;
        illegal_o  = (funct3 != 3'b000);
      end
      rv32i_pkg::OPC_BRANCH: begin
        op1_pc_o  = 1'b1;
        branch_o  = 1'b1;
        illegal_o = (funct3[2:1] == 2'b01);
      end
      rv32i_pkg::OPC_LOAD: begin
        rd_write_o = 1'b1;
        wb_sel_o   = rv32i_pkg::WB_LOAD;
        mem_read_o = 1'b1;
        illegal_o  = (funct3 != 3'b010);
      end
      rv32i_pkg::OPC_STORE: begin
        mem_write_o = 1'b1;
        illegal_o   = (funct3 != 3'b010);
      end
      rv32i_pkg::OPC_OPIMM: begin
        rd_write_o = 1'b1;
        alu_op_o   = rv32i_pkg::alu_op_t'({alt_op, funct3});
        illegal_o  = ((funct3 == 3'b001) && (funct7 != 7'h00)) ||
                     ((funct3 == 3'b101) && (funct7 != 7'h00) && (funct7 != 7'h20));
      end
      rv32i_pkg::OPC_OP: begin
        rd_write_o = 1'b1;
        op2_imm_o  = 1'b0;
        alu_op_o   = rv32i_pkg::alu_op_t'({alt_op, funct3});
        illegal_o  = (funct7 != 7'h00) &&
                     !((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      rv32i_pkg::OPC_SYSTEM: begin
        ebreak_o  = is_ebreak;
        illegal_o = !is_ebreak;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase

    // An illegal word must not write a register or touch the bus
    if (illegal_o) begin
      rd_write_o  = 1'b0;
      mem_read_o  = 1'b0;
      mem_write_o = 1'b0;
    end
  end

endmodule

// File: core/rv32i_execute.sv
module rv32i_execute (
  input  logic [rv32i_pkg::XLEN-1:0] pc_i,
  input  logic [rv32i_pkg::XLEN-1:0] rs1_i,
  input  logic [rv32i_pkg::XLEN-1:0] rs2_i,
  input  logic [rv32i_pkg::XLEN-1:0] imm_i,
  input  rv32i_pkg::alu_op_t         alu_op_i,
  input  logic                      op2_imm_i,
  input  logic                      op1_pc_i,
  input  logic                      branch_i,
  input  logic                      jump_i,
  input  logic                      jalr_i,
  input  logic [2:0]                funct3_i,
  output logic [rv32i_pkg::XLEN-1:0] alu_result_o,
  output logic [rv32i_pkg::XLEN-1:0] next_pc_o,
  output logic [rv32i_pkg::XLEN-1:0] pc_plus4_o
);

  logic [rv32i_pkg::XLEN-1:0] op1;
  logic [rv32i_pkg::XLEN-1:0] op2;
  logic [4:0]                 shamt;
  logic                       taken;

  assign op1   = op1_pc_i ? pc_i : rs1_i;
  assign op2   = op2_imm_i ? imm_i : rs2_i;
  assign shamt = op2[4:0];

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      rv32i_pkg::ALU_ADD:  alu_result_o = op1 + op2;
      rv32i_pkg::ALU_SUB:  alu_result_o = op1 - op2;
      rv32i_pkg::ALU_SLL:  alu_result_o = op1 << shamt;
      rv32i_pkg::ALU_SLT:  alu_result_o = {31'b0, $signed(op1) < $signed(op2)};
      rv32i_pkg::ALU_SLTU: alu_result_o = {31'b0, op1 < op2};
      rv32i_pkg::ALU_XOR:  alu_result_o = op1 ^ op2;
      rv32i_pkg::ALU_SRL:  alu_result_o = op1 >> shamt;
      rv32i_pkg::ALU_SRA:  alu_result_o = $signed(op1) >>> shamt;
      rv32i_pkg::ALU_OR:   alu_result_o = op1 | op2;
      rv32i_pkg::ALU_AND:  alu_result_o = op1 & op2;
      default:             alu_result_o = op1 + op2;
    endcase
  end

  // The comparator always sees the registers, since the ALU is busy with the target
  always_comb begin
    case (funct3_i)
      3'b000:  taken = (rs1_i == rs2_i);
      3'b001:  taken = (rs1_i != rs2_i);
      3'b100:  taken = ($signed(rs1_i) < $signed(rs2_i));
      3'b101:  taken = ($signed(rs1_i) >= $signed(rs2_i));
      3'b110:  taken = (rs1_i < rs2_i);
      3'b111:  taken = (rs1_i >= rs2_i);
      default: taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////

  assign pc_plus4_o = pc_i + 32'd4;

  // Bit 0 is cleared for JALR, and it is already zero for JAL and branches
  assign next_pc_o = (jump_i || jalr_i || (branch_i && taken)) ?
                     {alu_result_o[rv32i_pkg::XLEN-1:1], 1'b0} : pc_plus4_o;

endmodule

// File: core/rv32i_result.sv
module rv32i_result (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  rv32i_pkg::wb_sel_t         wb_sel_i,
  input  logic                      rd_write_i,
  input  logic [rv32i_pkg::XLEN-1:0] alu_result_i,
  input  logic [rv32i_pkg::XLEN-1:0] pc_plus4_i,
  input  logic [rv32i_pkg::XLEN-1:0] imm_i,
  input  logic [rv32i_pkg::XLEN-1:0] load_data_i,
  input  logic [rv32i_pkg::XLEN-1:0] next_pc_i,
  input  logic                      mem_op_i,
  input  logic                      mem_done_i,
  input  logic                      access_fault_i,
  input  logic                      ebreak_i,
  input  logic                      illegal_i,
  output logic [rv32i_pkg::XLEN-1:0] rd_data_o,
  output logic                      rd_write_o,
  output logic                      pc_write_o,
  output logic                      hold_o,
  output logic                      halted_o,
  output logic                      fault_o
);

  logic halted_q;
  logic fault_q;
  logic retire;

  always_comb begin
    case (wb_sel_i)
      rv32i_pkg::WB_PC4:  rd_data_o = pc_plus4_i;
      rv32i_pkg::WB_LOAD: rd_data_o = load_data_i;
      rv32i_pkg::WB_IMM:  rd_data_o = imm_i;
      default:            rd_data_o = alu_result_i;
    endcase
  end

  assign hold_o = halted_q | fault_q;

  // Memory instructions retire on the edge that ends their access
  assign retire = !hold_o && !illegal_i && !ebreak_i && (!mem_op_i || mem_done_i);

  assign rd_write_o = rd_write_i & retire;
  assign pc_write_o = retire;

  // Both flags stay set until the next reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      halted_q <= 1'b0;
      fault_q  <= 1'b0;
    end else if (!hold_o) begin
      halted_q <= ebreak_i;
      fault_q  <= illegal_i | access_fault_i;
    end
  end

  assign halted_o = halted_q;
  assign fault_o  = fault_q;

endmodule

// File: design/rv32i_apb_master.sv
module rv32i_apb_master (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      mem_read_i,
  input  logic                      mem_write_i,
  input  logic [rv32i_pkg::XLEN-1:0] addr_i,
  input  logic [rv32i_pkg::XLEN-1:0] wdata_i,
  input  logic                      hold_i,
  output logic [rv32i_pkg::XLEN-1:0] paddr_o,
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output logic [rv32i_pkg::XLEN-1:0] pwdata_o,
  input  logic [rv32i_pkg::XLEN-1:0] prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i,
  output logic                      mem_done_o,
  output logic [rv32i_pkg::XLEN-1:0] rdata_o,
  output logic                      access_fault_o
);

  logic                       in_window;
  logic                       request;
  logic                       access_end;
  logic                       psel_q;
  logic                       penable_q;
  logic                       pwrite_q;
  logic [rv32i_pkg::XLEN-1:0] paddr_q;
  logic [rv32i_pkg::XLEN-1:0] pwdata_q;

  assign in_window = (addr_i >= rv32i_pkg::DATA_BASE) && (addr_i < rv32i_pkg::DATA_END) &&
                     (addr_i[1:0] == 2'b00);

  // A new request is only seen in idle, so the held pc cannot launch it twice
  assign request    = (mem_read_i | mem_write_i) & !hold_i & !psel_q;
  assign access_end = psel_q & penable_q & pready_i;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  // Idle has psel low, setup has psel alone, access has both high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      psel_q    <= 1'b0;
      penable_q <= 1'b0;
    end else if (!psel_q) begin
      psel_q <= request & in_window;
    end else if (!penable_q) begin
      penable_q <= 1'b1;
    end else if (pready_i) begin
      psel_q    <= 1'b0;
      penable_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (request) begin
      paddr_q  <= addr_i;
      pwdata_q <= wdata_i;
      pwrite_q <= mem_write_i;
    end
  end

  assign paddr_o   = paddr_q;
  assign psel_o    = psel_q;
  assign penable_o = penable_q;
  assign pwrite_o  = pwrite_q;
  assign pwdata_o  = pwdata_q;

  assign mem_done_o     = access_end & !pslverr_i;
  assign rdata_o        = prdata_i;
  // A bad address faults before any bus cycle, a slave error at the end of one
  assign access_fault_o = (request & !in_window) | (access_end & pslverr_i);

endmodule

// File: design/rv32i.sv
module rv32i (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  output logic [rv32i_pkg::XLEN-1:0] instr_addr_o,
  input  logic [rv32i_pkg::XLEN-1:0] instr_i,
  output logic [rv32i_pkg::XLEN-1:0] paddr_o,
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output logic [rv32i_pkg::XLEN-1:0] pwdata_o,
  input  logic [rv32i_pkg::XLEN-1:0] prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i,
  output logic                      halted_o,
  output logic                      fault_o
);

  logic [rv32i_pkg::REG_BITS-1:0] rs1_addr;
  logic [rv32i_pkg::REG_BITS-1:0] rs2_addr;
  logic [rv32i_pkg::REG_BITS-1:0] rd_addr;
  logic [rv32i_pkg::XLEN-1:0]     imm;
  rv32i_pkg::alu_op_t             alu_op;
  rv32i_pkg::wb_sel_t             wb_sel;
  logic                           op2_imm;
  logic                           op1_pc;
  logic                           dec_rd_write;
  logic                           branch;
  logic                           jump;
  logic                           jalr;
  logic [2:0]                     funct3;
  logic                           mem_read;
  logic                           mem_write;
  logic                           ebreak;
  logic                           illegal;
  logic [rv32i_pkg::XLEN-1:0]     rs1;
  logic [rv32i_pkg::XLEN-1:0]     rs2;
  logic [rv32i_pkg::XLEN-1:0]     alu_result;
  logic [rv32i_pkg::XLEN-1:0]     next_pc;
  logic [rv32i_pkg::XLEN-1:0]     pc_plus4;
  logic                           mem_done;
  logic [rv32i_pkg::XLEN-1:0]     load_data;
  logic                           access_fault;
  logic [rv32i_pkg::XLEN-1:0]     rd_data;
  logic                           rd_write;
  logic                           pc_write;
  logic                           hold;

  // The pc leaves the register file straight onto the instruction port
  rv32i_registers i_registers (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rd_addr_i  (rd_addr),
    .rd_write_i (rd_write),
    .rd_data_i  (rd_data),
    .pc_write_i (pc_write),
    .pc_data_i  (next_pc),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .pc_o       (instr_addr_o)
  );

  rv32i_decode i_decode (
    .instr_i     (instr_i),
    .rs1_addr_o  (rs1_addr),
    .rs2_addr_o  (rs2_addr),
    .rd_addr_o   (rd_addr),
    .imm_o       (imm),
    .alu_op_o    (alu_op),
    .op2_imm_o   (op2_imm),
    .op1_pc_o    (op1_pc),
    .wb_sel_o    (wb_sel),
    .rd_write_o  (dec_rd_write),
    .branch_o    (branch),
    .jump_o      (jump),
    .jalr_o      (jalr),
    .funct3_o    (funct3),
    .mem_read_o  (mem_read),
    .mem_write_o (mem_write),
    .ebreak_o    (ebreak),
    .illegal_o   (illegal)
  );

  rv32i_execute i_execute (
    .pc_i         (instr_addr_o),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .imm_i        (imm),
    .alu_op_i     (alu_op),
    .op2_imm_i    (op2_imm),
    .op1_pc_i     (op1_pc),
    .branch_i     (branch),
    .jump_i       (jump),
    .jalr_i       (jalr),
    .funct3_i     (funct3),
    .alu_result_o (alu_result),
    .next_pc_o    (next_pc),
    .pc_plus4_o   (pc_plus4)
  );

  ////////////////////////////////////////////////////////////
  // Data window on APB
  ////////////////////////////////////////////////////////////

  rv32i_apb_master i_apb_master (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .mem_read_i     (mem_read),
    .mem_write_i    (mem_write),
    .addr_i         (alu_result),
    .wdata_i        (rs2),
    .hold_i         (hold),
    .paddr_o        (paddr_o),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .pwrite_o       (pwrite_o),
    .pwdata_o       (pwdata_o),
    .prdata_i       (prdata_i),
    .pready_i       (pready_i),
    .pslverr_i      (pslverr_i),
    .mem_done_o     (mem_done),
    .rdata_o        (load_data),
    .access_fault_o (access_fault)
  );

  rv32i_result i_result (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wb_sel_i       (wb_sel),
    .rd_write_i     (dec_rd_write),
    .alu_result_i   (alu_result),
    .pc_plus4_i     (pc_plus4),
    .imm_i          (imm),
    .load_data_i    (load_data),
    .next_pc_i      (next_pc),
    .mem_op_i       (mem_read | mem_write),
    .mem_done_i     (mem_done),
    .access_fault_i (access_fault),
    .ebreak_i       (ebreak),
    .illegal_i      (illegal),
    .rd_data_o      (rd_data),
    .rd_write_o     (rd_write),
    .pc_write_o     (pc_write),
    .hold_o         (hold),
    .halted_o       (halted_o),
    .fault_o        (fault_o)
  );

endmodule

// File: tb/rv32i_tb.sv
module rv32i_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HDR_A_LEN     = 0;
  localparam int HDR_B_LEN     = 1;
  localparam int HDR_RECORDS   = 2;
  localparam int HDR_B_RESTART = 3;
  localparam int HDR_FLAGS     = 4;
  localparam int HDR_XFER_B    = 7;
  localparam int HDR_XFER_A    = 9;
  localparam int PROG_A_BASE   = 16;
  localparam int PROG_B_BASE   = 112;
  localparam int RECORD_BASE   = 128;
  localparam int RUN_LIMIT     = 2000;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_addr;
  logic [31:0] instr;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        halted;
  logic        fault;

  logic [31:0] stim [0:255];
  logic [31:0] mem [0:255];
  int          rom_base;
  int          rom_len;
  bit          check_records;
  int          transfers;
  int          rec_idx;
  int unsigned lcg_state = 81810;

  rv32i i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .instr_addr_o (instr_addr),
    .instr_i      (instr),
    .paddr_o      (paddr),
    .psel_o       (psel),
    .penable_o    (penable),
    .pwrite_o     (pwrite),
    .pwdata_o     (pwdata),
    .prdata_i     (prdata),
    .pready_i     (pready),
    .pslverr_i    (pslverr),
    .halted_o     (halted),
    .fault_o      (fault)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Combinational instruction ROM, words past the program read as zero
  always_comb begin
    if ((instr_addr >> 2) < rom_len) begin
      instr = stim[rom_base + int'(instr_addr >> 2)];
    end else begin
      instr = 32'h0;
    end
  end

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    $display("TESTBENCH FAILED");
    $fatal(1, "Value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("Failure: %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Check failed");
  endtask

  ////////////////////////////////////////////////////////////
  // APB slave with random wait states and protocol checks
  ////////////////////////////////////////////////////////////

  initial begin : apb_slave
    logic        nxt_pready;
    logic        nxt_pslverr;
    logic [31:0] nxt_prdata;
    logic [31:0] cap_addr;
    logic [31:0] cap_wdata;
    logic        cap_write;
    logic        err_pending;
    logic        prev_psel;
    logic        prev_setup;
    int unsigned wait_left;
    cap_addr    = '0;
    cap_wdata   = '0;
    cap_write   = 1'b0;
    err_pending = 1'b0;
    prev_psel   = 1'b0;
    prev_setup  = 1'b0;
    wait_left   = 0;
    forever begin
      @(negedge clk);
      nxt_pready = 1'b0;
      assert (!penable || psel) else report_failure("penable_o is high without psel_o");
      if (!rst_n) begin
        assert (!psel && !penable) else report_failure("APB select is active during reset");
        transfers   = 0;
        rec_idx     = 0;
        prev_psel   = 1'b0;
        prev_setup  = 1'b0;
        err_pending = 1'b0;
        for (int i = 0; i < 256; i++) begin
          mem[i] = 32'h0;
        end
      end else begin
        assert (!prev_setup || (psel && penable))
          else report_failure("setup cycle is not followed by an access cycle");
        if (psel && !penable) begin
          assert (!prev_psel) else report_failure("setup cycle does not follow an idle cycle");
          cap_addr    = paddr;
          cap_wdata   = pwdata;
          cap_write   = pwrite;
          // The slave error test is recognized by its address and data
          err_pending = pwrite && (paddr == 32'h0000_23FC) && (pwdata == 32'hDEAD_0000);
          wait_left   = next_random() % 4;
          nxt_pready  = (wait_left == 0);
        end else if (psel && penable) begin
          assert (prev_psel) else report_failure("access cycle without a setup cycle");
          assert (paddr == cap_addr) else report_mismatch("paddr stable", cap_addr, paddr);
          assert (pwrite == cap_write)
            else report_mismatch("pwrite stable", 32'(cap_write), 32'(pwrite));
          if (cap_write) begin
            assert (pwdata == cap_wdata)
              else report_mismatch("pwdata stable", cap_wdata, pwdata);
          end
          if (pready) begin
            transfers++;
            if (cap_write && !err_pending) begin
              mem[cap_addr[9:2]] = cap_wdata;
            end
            if (cap_write && check_records) begin
              assert (rec_idx < int'(stim[HDR_RECORDS]))
                else report_failure("store beyond the expected record sequence");
              assert (cap_addr == stim[RECORD_BASE + 2 * rec_idx])
                else report_mismatch($sformatf("store %0d address", rec_idx),
                                     stim[RECORD_BASE + 2 * rec_idx], cap_addr);
              assert (cap_wdata == stim[RECORD_BASE + 2 * rec_idx + 1])
                else report_mismatch($sformatf("store %0d data", rec_idx),
                                     stim[RECORD_BASE + 2 * rec_idx + 1], cap_wdata);
              rec_idx++;
            end
          end else begin
            wait_left--;
            nxt_pready = (wait_left == 0);
          end
        end
        prev_psel  = psel;
        prev_setup = psel && !penable;
      end
      nxt_pslverr = nxt_pready && err_pending;
      nxt_prdata  = (nxt_pready && !cap_write) ? mem[cap_addr[9:2]] : 32'h0;
      @(posedge clk);
      #5;
      pready  = nxt_pready;
      pslverr = nxt_pslverr;
      prdata  = nxt_prdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    #5;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #5;
    rst_n = 1'b1;
    @(negedge clk);
    assert (instr_addr == 32'h0) else report_mismatch("pc after reset", 32'h0, instr_addr);
    assert (!halted && !fault) else report_failure("status flags are set after reset");
  endtask

  task automatic wait_for_end(input string name);
    int cycles;
    cycles = 0;
    while (!halted && !fault && (cycles < RUN_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    assert (halted || fault)
      else report_failure($sformatf("%s did not halt or fault within the timeout", name));
  endtask

  // After the end of a run the core must stay quiet
  task automatic check_frozen(input string name);
    logic [31:0] pc_seen;
    pc_seen = instr_addr;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (!psel) else report_failure($sformatf("%s starts an APB transfer after its end",
                                                   name));
      assert (instr_addr == pc_seen)
        else report_mismatch({name, " frozen pc"}, pc_seen, instr_addr);
    end
  endtask

  task automatic run_program(input string name, input int base, input int len,
                             input int flag_word, input int xfer_word, input bit records);
    rom_base      = base;
    rom_len       = len;
    check_records = records;
    apply_reset();
    wait_for_end(name);
    // Let a flag that rose late in the cycle settle before the comparison
    @(negedge clk);
    assert ({halted, fault} == stim[flag_word][1:0])
      else report_mismatch({name, " end flags"}, stim[flag_word], 32'({halted, fault}));
    check_frozen(name);
    assert (transfers == int'(stim[xfer_word]))
      else report_mismatch({name, " transfer count"}, stim[xfer_word], transfers);
    if (records) begin
      assert (rec_idx == int'(stim[HDR_RECORDS]))
        else report_mismatch({name, " store count"}, stim[HDR_RECORDS], rec_idx);
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    pready        = 1'b0;
    pslverr       = 1'b0;
    prdata        = 32'h0;
    rom_base      = 0;
    rom_len       = 0;
    check_records = 1'b0;
    $readmemh("tb/rv32i_stimulus.hex", stim);

    run_program("run A", PROG_A_BASE, int'(stim[HDR_A_LEN]), HDR_FLAGS, HDR_XFER_A, 1'b1);

    // Program B first hits the misaligned store, then restarts at the slave error test
    run_program("run B1", PROG_B_BASE, int'(stim[HDR_B_LEN]), HDR_FLAGS + 1, HDR_XFER_B,
                1'b0);
    run_program("run B2", PROG_B_BASE + int'(stim[HDR_B_RESTART]),
                int'(stim[HDR_B_LEN]) - int'(stim[HDR_B_RESTART]), HDR_FLAGS + 2,
                HDR_XFER_B + 1, 1'b0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: tb/rv32i_stimulus.hex
// Header: A length, B length, store records, B restart word, end flags {halted, fault}
// for A, B1, B2, then APB transfer counts for B1, B2 and A
@00
00000051 00000007 0000001E 00000003
00000002 00000001 00000001
00000000 00000001 00000020
// Program A: setup, then each result followed by its store
@10
00002537 FF900093 00500113
002081B3 00352023
402081B3 00352223
001111B3 00352423
0020A1B3 00352623
0020B1B3 00352823
0020C1B3 00352A23
0020D1B3 00352C23
4020D1B3 00352E23
0020E1B3 02352023
0020F1B3 02352223
06408193 02352423
FFF0A193 02352623
FFF0B193 02352823
0F00C193 02352A23
0060E193 02352C23
7FF0F193 02352E23
00409193 04352023
01C0D193 04352223
4020D193 04352423
ABCDE1B7 04352623
00001197 04352823
// Branches: taken ones skip a wrong store, not-taken ones store x2
00108463 00152023
00208463 04252A23
00209463 00152023
00109463 04252C23
0020C463 00152023
00114463 04252E23
00115463 00152023
0020D463 06252023
00116463 00152023
0020E463 06252223
0020F463 00152023
00117463 06252423
// JAL and JALR links, loads, derived store, EBREAK
0080026F 00152023 06452623
00000317 00D303E7 00152023 06752823
00052403 00452483 009401B3 06352A23
00100073
// Program B: misaligned store, then from word 3 the slave error store
@70
00002537 00052123 00100073
00002537 DEAD05B7 3EB52E23 00100073
// Expected store records for run A: address then data
@80
00002000 FFFFFFFE
00002004 FFFFFFF4
00002008 0A000000
0000200C 00000001
00002010 00000000
00002014 FFFFFFFC
00002018 07FFFFFF
0000201C FFFFFFFF
00002020 FFFFFFFD
00002024 00000001
00002028 0000005D
0000202C 00000001
00002030 00000001
00002034 FFFFFF09
00002038 FFFFFFFF
0000203C 000007F9
00002040 FFFFFF90
00002044 0000000F
00002048 FFFFFFFE
0000204C ABCDE000
00002050 000010AC
00002054 00000005
00002058 00000005
0000205C 00000005
00002060 00000005
00002064 00000005
00002068 00000005
0000206C 00000118
00002070 00000128
00002074 FFFFFFF2

// File: filelist.f
common/rv32i_pkg.sv
core/rv32i_registers.sv
core/rv32i_decode.sv
core/rv32i_execute.sv
core/rv32i_result.sv
design/rv32i_apb_master.sv
design/rv32i.sv
tb/rv32i_tb.sv
